//--- rtl/sram_selftest_settings.svh
`ifndef SRAM_SELFTEST_SETTINGS_SVH
`define SRAM_SELFTEST_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// sram geometry

`define SRAM_ADDR_WIDTH 10     // word address inside one bank
`define SRAM_DATA_WIDTH 36     // 32 data + 4 parity

//////////////////////////////////////////////////////////////////////
// bank select sits on top of the word address

`define SRAM_NUM_BANKS  4
`define BANK_SEL_WIDTH  2
`define REG_ADDR_WIDTH  12     // bank select + word address

`endif

//--- rtl/sram_bus_pkg.sv
`include "sram_selftest_settings.svh"

package sram_bus_pkg;

   //////////////////////////////////////////////////////////////////////
   // pin side vectors

   typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;
   typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;

   // everything the controller drives towards one sram part
   typedef struct packed {
      sram_addr_t addr;
      sram_data_t wr_data;
      logic       tri_en;    // drive wr_data onto the pads
      logic       we_bw;     // write enable, low active
   } sram_pins_t;

   //////////////////////////////////////////////////////////////////////
   // controller states

   typedef enum logic [2:0] {
      st_idle     = 3'd0,
      st_addr     = 3'd1,
      st_wait     = 3'd2,
      st_wait_flp = 3'd3,    // extra cycle so read data lines up
      st_data     = 3'd4,
      st_done     = 3'd5,
      st_hw_test  = 3'd6
   } sram_state_e;

endpackage

//--- rtl/reg_access_pkg.sv
`include "sram_selftest_settings.svh"

package reg_access_pkg;

   import sram_bus_pkg::*;

   typedef logic [`BANK_SEL_WIDTH-1:0] bank_sel_t;
   typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

   // cpu register request, held until ack
   typedef struct packed {
      logic       req;
      logic       rd_wr_l;
      reg_addr_t  addr;
      sram_data_t wr_data;
   } reg_req_t;

   // same request once the bank select is stripped off
   typedef struct packed {
      logic       req;
      logic       rd_wr_l;
      sram_addr_t addr;
      sram_data_t wr_data;
   } bank_req_t;

   // pattern engine word, valid whenever req is high
   typedef struct packed {
      logic       req;
      bank_sel_t  bank;
      sram_addr_t addr;
      sram_data_t wr_data;
      logic       tri_en;
      logic       we_bw;
   } test_req_t;

   typedef struct packed {
      logic       req;
      sram_addr_t addr;
      sram_data_t wr_data;
      logic       tri_en;
      logic       we_bw;
   } bank_test_t;

   typedef struct packed {
      logic       ack;       // one cycle pulse
      sram_data_t rd_data;
   } reg_resp_t;

endpackage

//--- rtl/reg_bank_decode.sv
`timescale 1ns/1ps
`include "sram_selftest_settings.svh"

module reg_bank_decode
   import sram_bus_pkg::*;
   import reg_access_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  reg_req_t   reg_in,
   input  test_req_t  test_in,
   input  logic       ack_seen,
   output bank_req_t  bank_req [`SRAM_NUM_BANKS],
   output bank_test_t bank_test [`SRAM_NUM_BANKS],
   output bank_sel_t  cpu_bank,
   output bank_sel_t  test_bank
);

   // pins, two sram cycles, capture register
   localparam int TEST_BANK_DELAY = 4;

   logic       req_q;
   logic       busy;          // cpu access in flight
   bank_sel_t  req_bank;
   sram_addr_t word_addr;
   bank_sel_t [TEST_BANK_DELAY-1:0] test_bank_pipe;

   assign req_bank  = reg_in.addr[`REG_ADDR_WIDTH-1 -: `BANK_SEL_WIDTH];
   assign word_addr = reg_in.addr[`SRAM_ADDR_WIDTH-1:0];

   //////////////////////////////////////////////////////////////////////
   // cpu side, bank is frozen at the rising edge of req

   always_ff @(posedge clk) begin
      if (reset) begin
         req_q    <= 1'b0;
         busy     <= 1'b0;
         cpu_bank <= '0;
      end else begin
         req_q <= reg_in.req;
         if (reg_in.req && !req_q) begin
            busy     <= 1'b1;
            cpu_bank <= req_bank;
         end else if (ack_seen || !reg_in.req) begin
            busy <= 1'b0;
         end else if (test_in.req && test_in.bank == cpu_bank) begin
            busy <= 1'b0;     // preempted, cpu has to retry
         end
      end
   end

   // bank of each test word, delayed to meet its read data
   always_ff @(posedge clk) begin
      if (reset) begin
         test_bank_pipe <= '0;
      end else begin
         test_bank_pipe <= {test_bank_pipe[TEST_BANK_DELAY-2:0], test_in.bank};
      end
   end

   assign test_bank = test_bank_pipe[TEST_BANK_DELAY-1];

   always_comb begin
      for (int i = 0; i < `SRAM_NUM_BANKS; i++) begin
         bank_req[i].req     = busy && reg_in.req && (cpu_bank == bank_sel_t'(i));
         bank_req[i].rd_wr_l = reg_in.rd_wr_l;
         bank_req[i].addr    = word_addr;
         bank_req[i].wr_data = reg_in.wr_data;

         bank_test[i].req     = test_in.req && (test_in.bank == bank_sel_t'(i));
         bank_test[i].addr    = test_in.addr;
         bank_test[i].wr_data = test_in.wr_data;
         bank_test[i].tri_en  = test_in.tri_en;
         bank_test[i].we_bw   = test_in.we_bw;
      end
   end

endmodule

//--- rtl/sram_port_ctrl.sv
`timescale 1ns/1ps

module sram_port_ctrl
   import sram_bus_pkg::*;
   import reg_access_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  bank_req_t  bank_req,
   input  bank_test_t bank_test,
   input  sram_data_t sram_rd_data,
   output sram_pins_t sram_out,
   output reg_resp_t  bank_resp,
   output sram_data_t bank_test_rd
);

   sram_state_e state;
   sram_state_e state_nxt;
   sram_pins_t  pins_nxt;
   logic        rd;           // current access is a read
   logic        rd_nxt;
   logic        ack_q;
   logic        ack_nxt;
   sram_data_t  rd_data_q;
   sram_data_t  rd_data_nxt;
   sram_data_t  sram_rd_data_d;

   //////////////////////////////////////////////////////////////////////
   // next state and next pin values

   always_comb begin
      pins_nxt        = sram_out;
      pins_nxt.tri_en = 1'b0;
      pins_nxt.we_bw  = 1'b1;
      rd_nxt          = rd;
      ack_nxt         = 1'b0;
      rd_data_nxt     = rd_data_q;
      state_nxt       = state;

      if (bank_test.req) begin
         // test engine owns the pins, cpu access is dropped
         pins_nxt.addr    = bank_test.addr;
         pins_nxt.wr_data = bank_test.wr_data;
         pins_nxt.tri_en  = bank_test.tri_en;
         pins_nxt.we_bw   = bank_test.we_bw;
         state_nxt        = st_hw_test;
      end else begin
         case (state)
            st_hw_test: state_nxt = st_idle;

            st_idle: begin
               if (bank_req.req) begin
                  pins_nxt.addr  = bank_req.addr;
                  pins_nxt.we_bw = bank_req.rd_wr_l;
                  rd_nxt         = bank_req.rd_wr_l;
                  state_nxt      = st_addr;
               end
            end

            st_addr: state_nxt = st_wait;

            st_wait: begin
               if (!rd) begin
                  pins_nxt.tri_en  = 1'b1;     // write data two cycles behind addr
                  pins_nxt.wr_data = bank_req.wr_data;
                  state_nxt        = st_data;
               end else begin
                  state_nxt = st_wait_flp;
               end
            end

            st_wait_flp: state_nxt = st_data;

            st_data: begin
               if (rd) begin
                  rd_data_nxt = sram_rd_data_d;
               end
               ack_nxt   = 1'b1;
               state_nxt = st_done;
            end

            st_done: begin
               if (!bank_req.req) begin
                  state_nxt = st_idle;
               end
            end

            default: state_nxt = st_idle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // registers

   always_ff @(posedge clk) begin
      if (reset) begin
         sram_out <= '{addr: '0, wr_data: '0, tri_en: 1'b0, we_bw: 1'b1};
         rd       <= 1'b1;
         ack_q    <= 1'b0;
         state    <= st_idle;
      end else begin
         sram_out <= pins_nxt;
         rd       <= rd_nxt;
         ack_q    <= ack_nxt;
         state    <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      sram_rd_data_d <= sram_rd_data;   // capture straight off the part
      rd_data_q      <= rd_data_nxt;
   end

   assign bank_resp    = '{ack: ack_q, rd_data: rd_data_q};
   assign bank_test_rd = sram_rd_data_d;

endmodule

//--- rtl/reg_resp_merge.sv
`timescale 1ns/1ps
`include "sram_selftest_settings.svh"

module reg_resp_merge
   import sram_bus_pkg::*;
   import reg_access_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  reg_resp_t  bank_resp [`SRAM_NUM_BANKS],
   input  sram_data_t bank_test_rd [`SRAM_NUM_BANKS],
   input  bank_sel_t  cpu_bank,
   input  bank_sel_t  test_bank,
   output reg_resp_t  reg_out,
   output sram_data_t test_rd_data
);

   logic       ack_q;
   sram_data_t rd_data_q;
   sram_data_t test_rd_q;
   reg_resp_t  cpu_resp;

   // only the bank holding the cpu access can answer
   assign cpu_resp = bank_resp[cpu_bank];

   //////////////////////////////////////////////////////////////////////
   // output stage

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= cpu_resp.ack;
      end
   end

   always_ff @(posedge clk) begin
      if (cpu_resp.ack) begin
         rd_data_q <= cpu_resp.rd_data;   // hold word for the cpu
      end
      test_rd_q <= bank_test_rd[test_bank];
   end

   // ack also goes back to the decoder
   assign reg_out      = '{ack: ack_q, rd_data: rd_data_q};
   assign test_rd_data = test_rd_q;

endmodule

//--- rtl/sram_selftest_top.sv
`timescale 1ns/1ps
`include "sram_selftest_settings.svh"

module sram_selftest_top
   import sram_bus_pkg::*;
   import reg_access_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  reg_req_t   reg_in,
   input  test_req_t  test_in,
   input  sram_data_t sram_rd_data [`SRAM_NUM_BANKS],
   output reg_resp_t  reg_out,
   output sram_data_t test_rd_data,
   output sram_pins_t sram_out [`SRAM_NUM_BANKS]
);

   bank_req_t  bank_req [`SRAM_NUM_BANKS];
   bank_test_t bank_test [`SRAM_NUM_BANKS];
   reg_resp_t  bank_resp [`SRAM_NUM_BANKS];
   sram_data_t bank_test_rd [`SRAM_NUM_BANKS];
   bank_sel_t  cpu_bank;
   bank_sel_t  test_bank;

   //////////////////////////////////////////////////////////////////////
   // request routing

   reg_bank_decode u_reg_bank_decode (
      .clk       (clk),
      .reset     (reset),
      .reg_in    (reg_in),
      .test_in   (test_in),
      .ack_seen  (reg_out.ack),
      .bank_req  (bank_req),
      .bank_test (bank_test),
      .cpu_bank  (cpu_bank),
      .test_bank (test_bank)
   );

   // one controller per sram part
   for (genvar i = 0; i < `SRAM_NUM_BANKS; i++) begin : g_bank
      sram_port_ctrl u_sram_port_ctrl (
         .clk          (clk),
         .reset        (reset),
         .bank_req     (bank_req[i]),
         .bank_test    (bank_test[i]),
         .sram_rd_data (sram_rd_data[i]),
         .sram_out     (sram_out[i]),
         .bank_resp    (bank_resp[i]),
         .bank_test_rd (bank_test_rd[i])
      );
   end

   reg_resp_merge u_reg_resp_merge (
      .clk          (clk),
      .reset        (reset),
      .bank_resp    (bank_resp),
      .bank_test_rd (bank_test_rd),
      .cpu_bank     (cpu_bank),
      .test_bank    (test_bank),
      .reg_out      (reg_out),
      .test_rd_data (test_rd_data)
   );

endmodule

//--- test/sram_model.sv
`timescale 1ns/1ps
`include "sram_selftest_settings.svh"

module sram_model
   import sram_bus_pkg::*;
#(
   parameter int BANK = 0
)(
   input  logic        clk,
   input  sram_pins_t  pins,
   output sram_data_t  rd_data,
   output int unsigned writes
);

   localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

   sram_data_t mem [DEPTH];
   sram_data_t rd_stage;       // first read register
   sram_addr_t wr_addr_q [2];
   logic       wr_q [2];       // late write pipeline

   // start-up contents depend on every address bit and the bank
   function automatic sram_data_t fill_word(input int a);
      sram_addr_t w;
      w = sram_addr_t'(a);
      return {4'ha, w, 2'(BANK), ~w, w ^ 10'h155};
   endfunction

   initial begin
      for (int a = 0; a < DEPTH; a++) begin
         mem[a] = fill_word(a);
      end
      wr_q[0] = 1'b0;
      wr_q[1] = 1'b0;
      writes  = 0;
   end

   //////////////////////////////////////////////////////////////////////
   // read data and write data both two edges after the command

   always @(posedge clk) begin
      rd_stage     <= mem[pins.addr];
      rd_data      <= rd_stage;
      wr_q[0]      <= !pins.we_bw;
      wr_addr_q[0] <= pins.addr;
      wr_q[1]      <= wr_q[0];
      wr_addr_q[1] <= wr_addr_q[0];
      if (wr_q[1]) begin
         mem[wr_addr_q[1]] <= pins.wr_data;
         writes            <= writes + 1;
      end
   end

endmodule

//--- test/sram_selftest_properties.sv
`timescale 1ns/1ps
`include "sram_selftest_settings.svh"

module sram_selftest_properties
   import sram_bus_pkg::*;
   import reg_access_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input reg_req_t   reg_in,
   input reg_resp_t  reg_out,
   input sram_pins_t sram_out [`SRAM_NUM_BANKS]
);

   ack_single_pulse: assert property (
      @(posedge clk) disable iff (reset) reg_out.ack |=> !reg_out.ack
   ) else $error("ack stayed high for more than one cycle");

   ack_needs_req: assert property (
      @(posedge clk) disable iff (reset) reg_out.ack |-> reg_in.req
   ) else $error("ack seen while no cpu request was pending");

   //////////////////////////////////////////////////////////////////////
   // pads only driven for a write, now or two cycles back

   for (genvar i = 0; i < `SRAM_NUM_BANKS; i++) begin : g_pins
      tri_en_on_write: assert property (
         @(posedge clk) disable iff (reset)
         sram_out[i].tri_en |-> (!sram_out[i].we_bw || $past(!sram_out[i].we_bw, 2))
      ) else $error("tri_en high on bank %0d during a read", i);
   end

endmodule

//--- test/sram_selftest_tb.sv
`timescale 1ns/1ps
`include "sram_selftest_settings.svh"

module sram_selftest_tb
   import sram_bus_pkg::*;
   import reg_access_pkg::*;
();

   localparam int NUM_ROWS        = 17;
   localparam int CYCLE_LIMIT     = NUM_ROWS * 12 + 50;
   localparam int WRITE_LATENCY   = 6;   // edges after the edge that drives req
   localparam int READ_LATENCY    = 7;
   localparam int TEST_RD_LATENCY = 5;   // edges after the edge that drives the test word
   localparam int PREEMPT_WATCH   = 8;
   localparam int DEPTH           = 1 << `SRAM_ADDR_WIDTH;

   typedef enum logic [2:0] {
      op_cpu_write, op_cpu_read, op_test_write, op_test_read, op_test_preempt
   } op_e;

   typedef struct packed {
      op_e        op;
      bank_sel_t  bank;
      sram_addr_t addr;
      sram_data_t data;
      sram_data_t expected;
   } row_t;

   logic        clk;
   logic        reset;
   reg_req_t    reg_in;
   test_req_t   test_in;
   sram_data_t  sram_rd_data [`SRAM_NUM_BANKS];
   reg_resp_t   reg_out;
   sram_data_t  test_rd_data;
   sram_pins_t  sram_out [`SRAM_NUM_BANKS];
   int unsigned bank_writes [`SRAM_NUM_BANKS];
   row_t        table_rows [NUM_ROWS];
   sram_data_t  scoreboard [`SRAM_NUM_BANKS][DEPTH];
   int          cycles = 0;

   sram_selftest_top u_sram_selftest_top (
      .clk          (clk),
      .reset        (reset),
      .reg_in       (reg_in),
      .test_in      (test_in),
      .sram_rd_data (sram_rd_data),
      .reg_out      (reg_out),
      .test_rd_data (test_rd_data),
      .sram_out     (sram_out)
   );

   for (genvar i = 0; i < `SRAM_NUM_BANKS; i++) begin : g_model
      sram_model #(.BANK(i)) u_sram_model (
         .clk     (clk),
         .pins    (sram_out[i]),
         .rd_data (sram_rd_data[i]),
         .writes  (bank_writes[i])
      );
   end

   bind sram_selftest_top sram_selftest_properties u_sram_selftest_properties (
      .clk      (clk),
      .reset    (reset),
      .reg_in   (reg_in),
      .reg_out  (reg_out),
      .sram_out (sram_out)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // helpers

   task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                        input string msg);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "check failed");
      end
   endtask

   // same start-up pattern as the sram models
   function automatic sram_data_t fill_word(input int b, input int a);
      sram_addr_t w;
      w = sram_addr_t'(a);
      return {4'ha, w, 2'(b), ~w, w ^ 10'h155};
   endfunction

   function automatic sram_data_t peek_word(input bank_sel_t b, input sram_addr_t a);
      case (b)
         2'd0:    return g_model[0].u_sram_model.mem[a];
         2'd1:    return g_model[1].u_sram_model.mem[a];
         2'd2:    return g_model[2].u_sram_model.mem[a];
         default: return g_model[3].u_sram_model.mem[a];
      endcase
   endfunction

   task automatic set_row(input int idx, input op_e op, input bank_sel_t b,
                          input sram_addr_t a);
      table_rows[idx].op       = op;
      table_rows[idx].bank     = b;
      table_rows[idx].addr     = a;
      table_rows[idx].data     = sram_data_t'({$urandom, $urandom});
      table_rows[idx].expected = '0;
   endtask

   task automatic build_table();
      set_row(0,  op_cpu_write,    2'd0, 10'h010);
      set_row(1,  op_cpu_write,    2'd1, 10'h3ff);
      set_row(2,  op_cpu_write,    2'd2, 10'h155);
      set_row(3,  op_cpu_write,    2'd3, 10'h2aa);
      set_row(4,  op_cpu_read,     2'd0, 10'h010);
      set_row(5,  op_cpu_read,     2'd1, 10'h3ff);
      set_row(6,  op_cpu_read,     2'd2, 10'h155);
      set_row(7,  op_cpu_read,     2'd3, 10'h2aa);
      set_row(8,  op_test_write,   2'd2, 10'h020);
      set_row(9,  op_cpu_read,     2'd2, 10'h020);
      set_row(10, op_test_read,    2'd2, 10'h020);
      set_row(11, op_test_write,   2'd1, 10'h0f0);
      set_row(12, op_test_read,    2'd1, 10'h0f0);
      set_row(13, op_test_read,    2'd3, 10'h2aa);
      set_row(14, op_test_preempt, 2'd0, 10'h010);
      set_row(15, op_cpu_read,     2'd3, 10'h300);   // never written
      set_row(16, op_test_preempt, 2'd3, 10'h2aa);
      for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
         for (int a = 0; a < DEPTH; a++) begin
            scoreboard[b][a] = fill_word(b, a);
         end
      end
      // walk the rows in order, writes update the scoreboard
      for (int i = 0; i < NUM_ROWS; i++) begin
         if (table_rows[i].op inside {op_cpu_write, op_test_write}) begin
            scoreboard[table_rows[i].bank][table_rows[i].addr] = table_rows[i].data;
         end
         table_rows[i].expected = scoreboard[table_rows[i].bank][table_rows[i].addr];
      end
   endtask

   task automatic check_idle();
      repeat (4) begin
         @(negedge clk);
         for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
            check(sram_out[b].tri_en, 1'b0, "tri_en after reset");
            check(sram_out[b].we_bw, 1'b1, "we_bw after reset");
         end
         check(reg_out.ack, 1'b0, "ack while idle");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // one access per task

   task automatic cpu_access(input row_t r, input logic rd);
      int          edges;
      int unsigned writes_before [`SRAM_NUM_BANKS];
      writes_before = bank_writes;
      @(posedge clk);
      reg_in <= '{req: 1'b1, rd_wr_l: rd, addr: {r.bank, r.addr}, wr_data: r.data};
      edges = 0;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (!reg_out.ack);
      check(edges, rd ? READ_LATENCY : WRITE_LATENCY, "ack latency");
      if (rd) begin
         check(reg_out.rd_data, r.expected, "cpu read data");
      end else begin
         check(peek_word(r.bank, r.addr), r.expected, "word in sram after cpu write");
      end
      for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
         check(bank_writes[b], writes_before[b] + ((!rd && b == r.bank) ? 1 : 0),
               "sram write count");
      end
      @(posedge clk);
      reg_in.req <= 1'b0;
      @(negedge clk);
      check(reg_out.ack, 1'b0, "ack dropped after one cycle");
      repeat (2) @(posedge clk);
   endtask

   task automatic test_write(input row_t r);
      int unsigned writes_before [`SRAM_NUM_BANKS];
      writes_before = bank_writes;
      @(posedge clk);
      test_in <= '{req: 1'b1, bank: r.bank, addr: r.addr, wr_data: r.data,
                   tri_en: 1'b1, we_bw: 1'b0};
      @(posedge clk);
      test_in.req <= 1'b0;
      @(negedge clk);
      check(sram_out[r.bank].addr, r.addr, "test write address on pins");
      check(sram_out[r.bank].wr_data, r.data, "test write data on pins");
      check(sram_out[r.bank].tri_en, 1'b1, "test write tri_en on pins");
      repeat (4) @(posedge clk);
      @(negedge clk);
      check(peek_word(r.bank, r.addr), r.expected, "word in sram after test write");
      for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
         check(bank_writes[b], writes_before[b] + ((b == r.bank) ? 1 : 0),
               "sram write count");
      end
   endtask

   task automatic test_read(input row_t r);
      @(posedge clk);
      test_in <= '{req: 1'b1, bank: r.bank, addr: r.addr, wr_data: '0,
                   tri_en: 1'b0, we_bw: 1'b1};
      @(posedge clk);
      test_in.req <= 1'b0;
      repeat (TEST_RD_LATENCY - 1) @(posedge clk);
      @(negedge clk);
      check(test_rd_data, r.expected, "test read data");
   endtask

   // test word hits the bank mid read, cpu retries
   task automatic preempt_read(input row_t r);
      @(posedge clk);
      reg_in <= '{req: 1'b1, rd_wr_l: 1'b1, addr: {r.bank, r.addr}, wr_data: '0};
      repeat (3) @(posedge clk);
      test_in <= '{req: 1'b1, bank: r.bank, addr: r.addr, wr_data: '0,
                   tri_en: 1'b0, we_bw: 1'b1};
      @(posedge clk);
      test_in.req <= 1'b0;
      repeat (PREEMPT_WATCH) begin
         @(negedge clk);
         check(reg_out.ack, 1'b0, "ack after preempted access");
      end
      @(posedge clk);
      reg_in.req <= 1'b0;
      repeat (2) @(posedge clk);
      cpu_access(r, 1'b1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      void'($urandom(73));
      reset   = 1'b1;
      reg_in  = '0;
      test_in = '0;
      build_table();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      check_idle();
      for (int i = 0; i < NUM_ROWS; i++) begin
         case (table_rows[i].op)
            op_cpu_write:  cpu_access(table_rows[i], 1'b0);
            op_cpu_read:   cpu_access(table_rows[i], 1'b1);
            op_test_write: test_write(table_rows[i]);
            op_test_read:  test_read(table_rows[i]);
            default:       preempt_read(table_rows[i]);
         endcase
      end
      $display("TEST OK");
      $finish;
   end

endmodule

//--- sram_selftest_top.f
+incdir+rtl
rtl/sram_bus_pkg.sv
rtl/reg_access_pkg.sv
rtl/reg_bank_decode.sv
rtl/sram_port_ctrl.sv
rtl/reg_resp_merge.sv
rtl/sram_selftest_top.sv
test/sram_model.sv
test/sram_selftest_properties.sv
test/sram_selftest_tb.sv

//--- Makefile
TOP = sram_selftest_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert \
		-f sram_selftest_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 \
		-f sram_selftest_top.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
